// ==== rtl/bridge_cfg_pkg.sv ====
// Sizes and thresholds of the host-to-FIFO bridge, referenced by scoped name from RTL and testbench
package bridge_cfg_pkg;

   // Width of one data word on every port and in every FIFO
   localparam int DATA_W = 32;

   // Downstream channel count, upstream uses the same count
   localparam int NUM_CHAN = 2;
   // Width of a channel index
   localparam int CHAN_W = 1;

   // Storage words in the memory of one FIFO
   localparam int FIFO_DEPTH = 64;
   // Address width for FIFO_DEPTH
   localparam int FIFO_AW = 6;

   // Writes accepted while total occupancy is below this level
   localparam int READY_LEVEL = 48;
   // Almost-empty flag set while total occupancy is below this level
   localparam int ALMOST_EMPTY_LEVEL = 4;

   // Arbiter sources, upstream channels first and status source last
   localparam int NUM_SRC = NUM_CHAN + 1;
   // Width of a source index
   localparam int SRC_W = 2;

   // Dropped-write counter width, saturates at all ones
   localparam int DROP_W = 16;

endpackage

// ==== rtl/host_bus_pkg.sv ====
// Host command and return word formats plus status word layout, used by the decoder, arbiter and top
package host_bus_pkg;

   // Status word filler above the used fields
   localparam int STATUS_PAD_W = bridge_cfg_pkg::DATA_W - bridge_cfg_pkg::DROP_W
                                 - bridge_cfg_pkg::NUM_CHAN;

   // Host command opcodes
   typedef enum logic [0:0] {
      // Push data word into the selected downstream channel
      OP_WRITE  = 1'b0,
      // Ask for one status word on the return bus
      OP_STATUS = 1'b1
   } host_op_e;

   // One host command, valid for a single cycle
   typedef struct packed {
      host_op_e                          op;
      // Downstream channel, ignored for status requests
      logic [bridge_cfg_pkg::CHAN_W-1:0] chan;
      // Payload, ignored for status requests
      logic [bridge_cfg_pkg::DATA_W-1:0] data;
   } host_cmd_t;

   // One word on the host return bus
   typedef struct packed {
      // Source that produced the word, NUM_CHAN marks status
      logic [bridge_cfg_pkg::SRC_W-1:0]  src;
      logic [bridge_cfg_pkg::DATA_W-1:0] data;
   } host_ret_t;

   // Status word as seen by the host
   typedef struct packed {
      // Always zero
      logic [STATUS_PAD_W-1:0]             pad;
      // One almost-empty flag per downstream channel
      logic [bridge_cfg_pkg::NUM_CHAN-1:0] dn_almost_empty;
      // Saturating count of dropped writes
      logic [bridge_cfg_pkg::DROP_W-1:0]   drops;
   } status_word_t;

endpackage

// ==== rtl/fwft_fifo.sv ====
// Synchronous first-word-fall-through FIFO instanced once per downstream and upstream channel
`timescale 1ns/1ns

module fwft_fifo (
   input  logic                              i_clock,
   input  logic                              i_arst_n,
   // Write side pulses i_wr only while o_wr_ready
   input  logic                              i_wr,
   input  logic [bridge_cfg_pkg::DATA_W-1:0] i_wr_data,
   output logic                              o_wr_ready,
   // Read side pulses i_rd only while o_rd_valid
   input  logic                              i_rd,
   output logic [bridge_cfg_pkg::DATA_W-1:0] o_rd_data,
   output logic                              o_rd_valid,
   output logic                              o_almost_empty
);

   // Storage array
   logic [bridge_cfg_pkg::DATA_W-1:0] mem [bridge_cfg_pkg::FIFO_DEPTH];

   // Pointers carry one extra wrap bit
   logic [bridge_cfg_pkg::FIFO_AW:0]   wr_ptr;
   logic [bridge_cfg_pkg::FIFO_AW:0]   wr_ptr_seen;
   logic [bridge_cfg_pkg::FIFO_AW:0]   rd_ptr;
   logic [bridge_cfg_pkg::FIFO_AW:0]   mem_count;
   // Memory words plus the two output stage bits
   logic [bridge_cfg_pkg::FIFO_AW+1:0] occupancy;

   // Output stages where B drives the port
   logic [bridge_cfg_pkg::DATA_W-1:0] a_data;
   logic [bridge_cfg_pkg::DATA_W-1:0] b_data;
   logic                              a_valid;
   logic                              b_valid;

   // Stage advance strobes
   logic a_load;
   logic b_load;

   // B takes A when B is empty or being read
   assign b_load = a_valid & (~b_valid | i_rd);
   // A takes a memory word when A is empty or moving on to B
   assign a_load = (rd_ptr != wr_ptr_seen) & (~a_valid | b_load);

   assign mem_count = wr_ptr - rd_ptr;
   assign occupancy = {1'b0, mem_count}
                    + (bridge_cfg_pkg::FIFO_AW + 2)'(a_valid)
                    + (bridge_cfg_pkg::FIFO_AW + 2)'(b_valid);

   // Levels come straight from registered state
   assign o_wr_ready     = occupancy < bridge_cfg_pkg::READY_LEVEL;
   assign o_almost_empty = occupancy < bridge_cfg_pkg::ALMOST_EMPTY_LEVEL;

   assign o_rd_data  = b_data;
   assign o_rd_valid = b_valid;

   always_ff @(posedge i_clock) begin
      if (i_wr) begin
         mem[wr_ptr[bridge_cfg_pkg::FIFO_AW-1:0]] <= i_wr_data;
      end
   end

   // Stage payloads follow their load strobes
   always_ff @(posedge i_clock) begin
      if (a_load) begin
         a_data <= mem[rd_ptr[bridge_cfg_pkg::FIFO_AW-1:0]];
      end
      if (b_load) begin
         b_data <= a_data;
      end
   end

   always_ff @(posedge i_clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wr_ptr      <= '0;
         wr_ptr_seen <= '0;
         rd_ptr      <= '0;
         a_valid     <= 1'b0;
         b_valid     <= 1'b0;
      end else begin
         wr_ptr <= wr_ptr + (bridge_cfg_pkg::FIFO_AW + 1)'(i_wr);
         // Read side sees new words one edge after the write as with a RAM write port
         wr_ptr_seen <= wr_ptr;
         rd_ptr      <= rd_ptr + (bridge_cfg_pkg::FIFO_AW + 1)'(a_load);
         a_valid     <= a_load | (a_valid & ~b_load);
         b_valid     <= b_load | (b_valid & ~i_rd);
      end
   end

endmodule

// ==== rtl/host_cmd_decoder.sv ====
// Host command decoder, routes writes to downstream FIFOs and holds the pending status request
`timescale 1ns/1ns

module host_cmd_decoder (
   input  logic                                i_clock,
   input  logic                                i_arst_n,
   // One command per cycle, no back-pressure
   input  host_bus_pkg::host_cmd_t             i_cmd,
   input  logic                                i_cmd_valid,
   // Downstream FIFO write ports
   output logic [bridge_cfg_pkg::NUM_CHAN-1:0] o_dn_wr,
   output logic [bridge_cfg_pkg::DATA_W-1:0]   o_dn_wr_data,
   input  logic [bridge_cfg_pkg::NUM_CHAN-1:0] i_dn_wr_ready,
   input  logic [bridge_cfg_pkg::NUM_CHAN-1:0] i_dn_almost_empty,
   // Status source toward the arbiter
   output logic                                o_status_valid,
   output host_bus_pkg::status_word_t          o_status,
   input  logic                                i_status_grant
);

   logic                              is_write;
   logic                              is_status;
   logic                              wr_drop;
   logic [bridge_cfg_pkg::DROP_W-1:0] drop_count;
   logic                              status_pending;

   assign is_write  = i_cmd_valid & (i_cmd.op == host_bus_pkg::OP_WRITE);
   assign is_status = i_cmd_valid & (i_cmd.op == host_bus_pkg::OP_STATUS);

   // Target channel full, the word is lost
   assign wr_drop = is_write & ~i_dn_wr_ready[i_cmd.chan];

   // Same cycle as the command
   always_comb begin
      for (int c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin
         o_dn_wr[c] = is_write & (i_cmd.chan == bridge_cfg_pkg::CHAN_W'(c))
                    & i_dn_wr_ready[c];
      end
   end

   // Data fans out to every channel, the strobe picks one
   assign o_dn_wr_data = i_cmd.data;

   // Saturating drop counter
   always_ff @(posedge i_clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         drop_count <= '0;
      end else if (wr_drop && (drop_count != '1)) begin
         drop_count <= drop_count + 1'b1;
      end
   end

   // Pending flag, a request during a pending one merges into it
   always_ff @(posedge i_clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         status_pending <= 1'b0;
      end else begin
         status_pending <= (status_pending | is_status) & ~i_status_grant;
      end
   end

   assign o_status_valid = status_pending;

   // Word is sampled by the arbiter on the grant edge
   always_comb begin
      o_status                 = '0;
      o_status.dn_almost_empty = i_dn_almost_empty;
      o_status.drops           = drop_count;
   end

endmodule

// ==== rtl/host_return_arbiter.sv ====
// Round-robin arbiter that loads the host return register from upstream FIFOs and the status source
`timescale 1ns/1ns

module host_return_arbiter (
   input  logic                                                         i_clock,
   input  logic                                                         i_arst_n,
   // Sources with upstream channels first and status last
   input  logic [bridge_cfg_pkg::NUM_SRC-1:0]                           i_src_valid,
   input  logic [bridge_cfg_pkg::NUM_SRC-1:0][bridge_cfg_pkg::DATA_W-1:0] i_src_data,
   output logic [bridge_cfg_pkg::NUM_SRC-1:0]                           o_src_read,
   // Host return bus
   output host_bus_pkg::host_ret_t                                      o_ret,
   output logic                                                         o_ret_valid,
   input  logic                                                         i_ret_ready
);

   // Last granted source where round robin restarts
   logic [bridge_cfg_pkg::SRC_W-1:0] last_grant;
   logic [bridge_cfg_pkg::SRC_W-1:0] scan_idx;
   logic [bridge_cfg_pkg::SRC_W-1:0] grant_idx;
   logic                             grant_found;
   logic                             load;

   // Return register
   host_bus_pkg::host_ret_t ret_q;
   logic                    ret_valid;

   // Scan from last_grant + 1 and wrap over all sources
   always_comb begin
      grant_found = 1'b0;
      grant_idx   = last_grant;
      scan_idx    = last_grant;
      for (int k = 1; k <= bridge_cfg_pkg::NUM_SRC; k++) begin
         scan_idx = bridge_cfg_pkg::SRC_W'((int'(last_grant) + k) % bridge_cfg_pkg::NUM_SRC);
         if (!grant_found && i_src_valid[scan_idx]) begin
            grant_found = 1'b1;
            grant_idx   = scan_idx;
         end
      end
   end

   // Register free or being accepted this cycle
   assign load = (~ret_valid | i_ret_ready) & grant_found;

   // Pop pulse that doubles as the status grant for the last source
   always_comb begin
      o_src_read = '0;
      if (load) begin
         o_src_read[grant_idx] = 1'b1;
      end
   end

   // Payload held while waiting for the host
   always_ff @(posedge i_clock) begin
      if (load) begin
         ret_q.src  <= grant_idx;
         ret_q.data <= i_src_data[grant_idx];
      end
   end

   always_ff @(posedge i_clock or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ret_valid  <= 1'b0;
         // First scan begins at source 0
         last_grant <= bridge_cfg_pkg::SRC_W'(bridge_cfg_pkg::NUM_SRC - 1);
      end else begin
         if (load) begin
            ret_valid  <= 1'b1;
            last_grant <= grant_idx;
         end else if (i_ret_ready) begin
            ret_valid <= 1'b0;
         end
      end
   end

   assign o_ret       = ret_q;
   assign o_ret_valid = ret_valid;

endmodule

// ==== rtl/pcie_fifo_bridge.sv ====
// Top level of the host-to-FIFO bridge, connects decoder, channel FIFOs and return arbiter
`timescale 1ns/1ns

module pcie_fifo_bridge (
   input  logic                                                          i_clock,
   input  logic                                                          i_arst_n,
   // Host command port
   input  host_bus_pkg::host_cmd_t                                       i_cmd,
   input  logic                                                          i_cmd_valid,
   // Downstream channels toward user logic
   output logic [bridge_cfg_pkg::NUM_CHAN-1:0][bridge_cfg_pkg::DATA_W-1:0] o_dn_data,
   output logic [bridge_cfg_pkg::NUM_CHAN-1:0]                           o_dn_valid,
   input  logic [bridge_cfg_pkg::NUM_CHAN-1:0]                           i_dn_read,
   output logic [bridge_cfg_pkg::NUM_CHAN-1:0]                           o_dn_almost_empty,
   // Upstream channels from user logic
   input  logic [bridge_cfg_pkg::NUM_CHAN-1:0][bridge_cfg_pkg::DATA_W-1:0] i_up_data,
   input  logic [bridge_cfg_pkg::NUM_CHAN-1:0]                           i_up_valid,
   output logic [bridge_cfg_pkg::NUM_CHAN-1:0]                           o_up_ready,
   // Host return bus
   output host_bus_pkg::host_ret_t                                       o_ret,
   output logic                                                          o_ret_valid,
   input  logic                                                          i_ret_ready
);

   // Decoder to downstream FIFOs
   logic [bridge_cfg_pkg::NUM_CHAN-1:0] dn_wr;
   logic [bridge_cfg_pkg::DATA_W-1:0]   dn_wr_data;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0] dn_wr_ready;

   // Arbiter source bundle, index NUM_CHAN is status
   logic [bridge_cfg_pkg::NUM_SRC-1:0]                           src_valid;
   logic [bridge_cfg_pkg::NUM_SRC-1:0][bridge_cfg_pkg::DATA_W-1:0] src_data;
   logic [bridge_cfg_pkg::NUM_SRC-1:0]                           src_read;
   host_bus_pkg::status_word_t                                   status_word;

   for (genvar c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin : g_chan
      // Host to user logic
      fwft_fifo u_dn_fifo (
         .i_clock        (i_clock),
         .i_arst_n       (i_arst_n),
         .i_wr           (dn_wr[c]),
         .i_wr_data      (dn_wr_data),
         .o_wr_ready     (dn_wr_ready[c]),
         .i_rd           (i_dn_read[c]),
         .o_rd_data      (o_dn_data[c]),
         .o_rd_valid     (o_dn_valid[c]),
         .o_almost_empty (o_dn_almost_empty[c])
      );

      // User logic to host, drained by the arbiter
      // Upstream almost-empty level has no consumer
      fwft_fifo u_up_fifo (
         .i_clock        (i_clock),
         .i_arst_n       (i_arst_n),
         .i_wr           (i_up_valid[c]),
         .i_wr_data      (i_up_data[c]),
         .o_wr_ready     (o_up_ready[c]),
         .i_rd           (src_read[c]),
         .o_rd_data      (src_data[c]),
         .o_rd_valid     (src_valid[c]),
         .o_almost_empty ()
      );
   end

   host_cmd_decoder u_decoder (
      .i_clock           (i_clock),
      .i_arst_n          (i_arst_n),
      .i_cmd             (i_cmd),
      .i_cmd_valid       (i_cmd_valid),
      .o_dn_wr           (dn_wr),
      .o_dn_wr_data      (dn_wr_data),
      .i_dn_wr_ready     (dn_wr_ready),
      .i_dn_almost_empty (o_dn_almost_empty),
      .o_status_valid    (src_valid[bridge_cfg_pkg::NUM_CHAN]),
      .o_status          (status_word),
      .i_status_grant    (src_read[bridge_cfg_pkg::NUM_CHAN])
   );

   // Status word rides the last source slot
   assign src_data[bridge_cfg_pkg::NUM_CHAN] = status_word;

   host_return_arbiter u_arbiter (
      .i_clock     (i_clock),
      .i_arst_n    (i_arst_n),
      .i_src_valid (src_valid),
      .i_src_data  (src_data),
      .o_src_read  (src_read),
      .o_ret       (o_ret),
      .o_ret_valid (o_ret_valid),
      .i_ret_ready (i_ret_ready)
   );

endmodule

// ==== tests/pcie_fifo_bridge_sva.sv ====
// Concurrent checks on FIFO handshakes and return arbiter control bound into every instance
`timescale 1ns/1ns

module pcie_fifo_bridge_sva (
   input logic                               i_clock,
   input logic                               i_arst_n,
   // FIFO side tied off in the arbiter binding
   input logic                               i_wr,
   input logic                               i_wr_ready,
   input logic                               i_rd,
   input logic                               i_rd_valid,
   // Arbiter side tied off in the FIFO binding
   input logic [bridge_cfg_pkg::NUM_SRC-1:0] i_src_read,
   input logic [bridge_cfg_pkg::NUM_SRC-1:0] i_src_valid,
   input host_bus_pkg::host_ret_t            i_ret,
   input logic                               i_ret_valid,
   input logic                               i_ret_ready
);

   // Count of failed assertions in this instance
   int fail_count = 0;

   // Pop only a word that is shown
   a_no_empty_read: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      (i_rd |-> i_rd_valid) and ((i_src_read & ~i_src_valid) == '0))
      else begin
         fail_count++;
         $error("Read of an empty FIFO or source");
      end

   a_no_full_write: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      i_wr |-> i_wr_ready)
      else begin
         fail_count++;
         $error("Write to a FIFO that is not ready");
      end

   a_one_grant: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      $onehot0(i_src_read))
      else begin
         fail_count++;
         $error("More than one source granted");
      end

   // Return word frozen until the host takes it
   a_ret_stable: assert property (@(posedge i_clock) disable iff (!i_arst_n)
      (i_ret_valid && !i_ret_ready) |=> (i_ret_valid && $stable(i_ret)))
      else begin
         fail_count++;
         $error("o_ret changed or dropped before acceptance");
      end

endmodule

bind fwft_fifo pcie_fifo_bridge_sva u_sva (
   .i_clock     (i_clock),
   .i_arst_n    (i_arst_n),
   .i_wr        (i_wr),
   .i_wr_ready  (o_wr_ready),
   .i_rd        (i_rd),
   .i_rd_valid  (o_rd_valid),
   .i_src_read  ('0),
   .i_src_valid ('0),
   .i_ret       ('0),
   .i_ret_valid (1'b0),
   .i_ret_ready (1'b1)
);

bind host_return_arbiter pcie_fifo_bridge_sva u_sva (
   .i_clock     (i_clock),
   .i_arst_n    (i_arst_n),
   .i_wr        (1'b0),
   .i_wr_ready  (1'b1),
   .i_rd        (1'b0),
   .i_rd_valid  (1'b1),
   .i_src_read  (o_src_read),
   .i_src_valid (i_src_valid),
   .i_ret       (o_ret),
   .i_ret_valid (o_ret_valid),
   .i_ret_ready (i_ret_ready)
);

// ==== tests/pcie_fifo_bridge_tb.sv ====
// Top-level randomized testbench that checks the host-to-FIFO bridge against a queue model
`timescale 1ns/1ns

module pcie_fifo_bridge_tb;

   localparam int          CLK_PERIOD   = 20;
   localparam int          RESET_CYCLES = 16;
   localparam int          NUM_CYCLES   = 4000;
   // Back-to-back commands with no reads saturate the drop counter within this length
   localparam int          FLOOD_CYCLES = 72000;
   // Host-busy and user-busy phases alternate at this length
   localparam int          PHASE_CYCLES = 500;
   localparam int          DRAIN_CYCLES = 1000;
   localparam int          WATCHDOG_NS  =
      (RESET_CYCLES + NUM_CYCLES + FLOOD_CYCLES + DRAIN_CYCLES) * CLK_PERIOD;
   localparam logic [31:0] LCG_SEED     = 32'd54898;

   logic                                                           i_clock;
   logic                                                           i_arst_n;
   host_bus_pkg::host_cmd_t                                        i_cmd;
   logic                                                           i_cmd_valid;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0][bridge_cfg_pkg::DATA_W-1:0] o_dn_data;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0]                            o_dn_valid;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0]                            i_dn_read;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0]                            o_dn_almost_empty;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0][bridge_cfg_pkg::DATA_W-1:0] i_up_data;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0]                            i_up_valid;
   logic [bridge_cfg_pkg::NUM_CHAN-1:0]                            o_up_ready;
   host_bus_pkg::host_ret_t                                        o_ret;
   logic                                                           o_ret_valid;
   logic                                                           i_ret_ready;

   // Model queues holding the words inside each FIFO
   logic [bridge_cfg_pkg::DATA_W-1:0] dn_q [bridge_cfg_pkg::NUM_CHAN][$];
   logic [bridge_cfg_pkg::DATA_W-1:0] up_q [bridge_cfg_pkg::NUM_CHAN][$];
   logic [bridge_cfg_pkg::DROP_W-1:0] drops;
   // Pending status flag as the arbiter sees it
   logic                              pend;
   // Status request taken at the coming edge
   logic                              req_prev;
   // Status word offered in the previous cycle
   host_bus_pkg::status_word_t        status_snap;
   host_bus_pkg::host_ret_t           prev_ret;
   logic                              prev_ret_valid;
   logic                              prev_ret_ready;
   logic [31:0]                       lcg_state;
   int                                cycle_no;

   pcie_fifo_bridge uut (
      .i_clock           (i_clock),
      .i_arst_n          (i_arst_n),
      .i_cmd             (i_cmd),
      .i_cmd_valid       (i_cmd_valid),
      .o_dn_data         (o_dn_data),
      .o_dn_valid        (o_dn_valid),
      .i_dn_read         (i_dn_read),
      .o_dn_almost_empty (o_dn_almost_empty),
      .i_up_data         (i_up_data),
      .i_up_valid        (i_up_valid),
      .o_up_ready        (o_up_ready),
      .o_ret             (o_ret),
      .o_ret_valid       (o_ret_valid),
      .i_ret_ready       (i_ret_ready)
   );

   initial begin
      i_clock = 1'b0;
      forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic fail_run(input string line);
      $display("%s", line);
      $display("Simulation failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_dn(input logic [bridge_cfg_pkg::DATA_W-1:0] got,
                           input logic [bridge_cfg_pkg::DATA_W-1:0] exp, input int chan);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: channel %0d downstream data %h, expected %h",
                            $time, chan, got, exp));
      end
   endtask

   task automatic check_ret(input host_bus_pkg::host_ret_t got,
                            input host_bus_pkg::host_ret_t exp);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: o_ret src %0d data %h, expected src %0d data %h",
                            $time, got.src, got.data, exp.src, exp.data));
      end
   endtask

   task automatic check_status(input host_bus_pkg::status_word_t got,
                               input host_bus_pkg::status_word_t exp);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: status word %h, expected %h", $time, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   // Match the word just loaded into the return register to its source
   task automatic take_return(output logic grant);
      host_bus_pkg::host_ret_t exp;
      int                      src;
      int                      hit;
      grant = 1'b0;
      src   = int'(o_ret.src);
      hit   = -1;
      exp   = '0;
      if (src == bridge_cfg_pkg::NUM_CHAN && pend) begin
         grant = 1'b1;
         check_status(host_bus_pkg::status_word_t'(o_ret.data), status_snap);
      end else if (src == bridge_cfg_pkg::NUM_CHAN) begin
         fail_run($sformatf("ERROR at %0t ns: status word returned with no request pending",
                            $time));
      end else begin
         // An upstream word must sit at the head of one channel queue
         for (int c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin
            if (hit < 0 && up_q[c].size() != 0 && up_q[c][0] == o_ret.data) begin
               hit = c;
            end
         end
         if (hit < 0) begin
            fail_run($sformatf("ERROR at %0t ns: unexpected return word %h from source %0d",
                               $time, o_ret.data, src));
         end else begin
            exp.src  = bridge_cfg_pkg::SRC_W'(hit);
            exp.data = up_q[hit].pop_front();
            check_ret(o_ret, exp);
         end
      end
   endtask

   // Failure counts kept by the bound assertion instances
   function automatic int assertion_failures();
      return uut.g_chan[0].u_dn_fifo.u_sva.fail_count + uut.g_chan[1].u_dn_fifo.u_sva.fail_count
           + uut.g_chan[0].u_up_fifo.u_sva.fail_count + uut.g_chan[1].u_up_fifo.u_sva.fail_count
           + uut.u_arbiter.u_sva.fail_count;
   endfunction

   // Check outputs at the falling edge and drive the next cycle at the rising edge
   task automatic cycle_step(input bit draining, input bit flooding);
      host_bus_pkg::host_cmd_t                                        nxt_cmd;
      logic                                                           nxt_cmd_valid;
      logic [bridge_cfg_pkg::NUM_CHAN-1:0]                            nxt_rd;
      logic [bridge_cfg_pkg::NUM_CHAN-1:0]                            nxt_up_valid;
      logic [bridge_cfg_pkg::NUM_CHAN-1:0][bridge_cfg_pkg::DATA_W-1:0] nxt_up_data;
      logic                                                           nxt_ready;
      logic                                                           busy_host;
      logic                                                           grant;
      logic [31:0]                                                    r;
      @(negedge i_clock);
      if (assertion_failures() != 0) begin
         fail_run($sformatf("A bound assertion failed before %0t ns", $time));
      end
      grant = 1'b0;
      if (prev_ret_valid && !prev_ret_ready) begin
         // Word held under back-pressure
         check_flag(o_ret_valid, 1'b1, "o_ret_valid under back-pressure");
         check_ret(o_ret, prev_ret);
      end else if (o_ret_valid) begin
         // Any other valid word is a fresh load
         take_return(grant);
      end
      pend        = (pend | req_prev) & ~grant;
      status_snap = '0;
      for (int c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin
         check_flag(o_dn_almost_empty[c], dn_q[c].size() < bridge_cfg_pkg::ALMOST_EMPTY_LEVEL,
                    "o_dn_almost_empty");
         check_flag(o_up_ready[c], up_q[c].size() < bridge_cfg_pkg::READY_LEVEL, "o_up_ready");
         if (o_dn_valid[c]) begin
            if (dn_q[c].size() == 0) begin
               fail_run($sformatf("ERROR at %0t ns: channel %0d shows a word never written",
                                  $time, c));
            end
            check_dn(o_dn_data[c], dn_q[c][0], c);
         end
         status_snap.dn_almost_empty[c] = dn_q[c].size() < bridge_cfg_pkg::ALMOST_EMPTY_LEVEL;
      end
      status_snap.drops = drops;
      prev_ret          = o_ret;
      prev_ret_valid    = o_ret_valid;
      prev_ret_ready    = i_ret_ready;
      // Acceptance uses occupancy before this cycle's read
      if (i_cmd_valid && i_cmd.op == host_bus_pkg::OP_WRITE) begin
         if (dn_q[i_cmd.chan].size() < bridge_cfg_pkg::READY_LEVEL) begin
            dn_q[i_cmd.chan].push_back(i_cmd.data);
         end else if (drops != '1) begin
            drops = drops + 1'b1;
         end
      end
      req_prev = i_cmd_valid && (i_cmd.op == host_bus_pkg::OP_STATUS);
      for (int c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin
         if (i_dn_read[c]) begin
            void'(dn_q[c].pop_front());
         end
         if (i_up_valid[c]) begin
            up_q[c].push_back(i_up_data[c]);
         end
      end
      busy_host     = ((cycle_no / PHASE_CYCLES) % 2) == 0;
      r             = lcg_next();
      nxt_cmd_valid = !draining && (flooding || r[31:29] != 3'd0);
      nxt_cmd.op    = (r[28:25] == 4'd0) ? host_bus_pkg::OP_STATUS : host_bus_pkg::OP_WRITE;
      nxt_cmd.chan  = r[24 -: bridge_cfg_pkg::CHAN_W];
      nxt_cmd.data  = lcg_next();
      for (int c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin
         r = lcg_next();
         // A word seen and not read stays valid one more cycle
         nxt_rd[c] = !flooding && o_dn_valid[c] && !i_dn_read[c]
                   && (draining || r[31:29] < (busy_host ? 3'd1 : 3'd7));
         // Later reads only lower occupancy so ready is certain
         nxt_up_valid[c] = !draining && !flooding
                         && (up_q[c].size() < bridge_cfg_pkg::READY_LEVEL)
                         && (r[28:27] != 2'd0);
         nxt_up_data[c]  = lcg_next();
      end
      r         = lcg_next();
      nxt_ready = draining || flooding || r[31:29] < (busy_host ? 3'd7 : 3'd2);
      @(posedge i_clock);
      i_cmd       <= nxt_cmd;
      i_cmd_valid <= nxt_cmd_valid;
      i_dn_read   <= nxt_rd;
      i_up_valid  <= nxt_up_valid;
      i_up_data   <= nxt_up_data;
      i_ret_ready <= nxt_ready;
      cycle_no++;
   endtask

   function automatic bit model_idle();
      bit idle;
      idle = !pend && !req_prev && !prev_ret_valid;
      for (int c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin
         idle = idle && (dn_q[c].size() == 0) && (up_q[c].size() == 0);
      end
      return idle;
   endfunction

   initial begin
      #(WATCHDOG_NS);
      fail_run("Timeout, the bridge did not finish returning and draining its words in time");
   end

   initial begin
      i_arst_n       = 1'b0;
      i_cmd          = '0;
      i_cmd_valid    = 1'b0;
      i_dn_read      = '0;
      i_up_data      = '0;
      i_up_valid     = '0;
      i_ret_ready    = 1'b0;
      lcg_state      = LCG_SEED;
      drops          = '0;
      pend           = 1'b0;
      req_prev       = 1'b0;
      status_snap    = '0;
      prev_ret       = '0;
      prev_ret_valid = 1'b0;
      prev_ret_ready = 1'b0;
      cycle_no       = 0;
      repeat (RESET_CYCLES - 1) @(posedge i_clock);
      @(negedge i_clock);
      // Control outputs while reset is held
      check_flag(o_ret_valid, 1'b0, "o_ret_valid in reset");
      for (int c = 0; c < bridge_cfg_pkg::NUM_CHAN; c++) begin
         check_flag(o_dn_valid[c], 1'b0, "o_dn_valid in reset");
         check_flag(o_up_ready[c], 1'b1, "o_up_ready in reset");
         check_flag(o_dn_almost_empty[c], 1'b1, "o_dn_almost_empty in reset");
      end
      @(posedge i_clock);
      i_arst_n <= 1'b1;
      repeat (NUM_CYCLES) cycle_step(1'b0, 1'b0);
      // Full channels turn nearly every write into a drop
      repeat (FLOOD_CYCLES) cycle_step(1'b0, 1'b1);
      // Drain until nothing is left in flight and idle a little
      while (!model_idle()) cycle_step(1'b1, 1'b0);
      repeat (8) cycle_step(1'b1, 1'b0);
      if (assertion_failures() == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("Simulation failed");
         $fatal(1, "Bound assertions reported failures");
      end
   end

endmodule

// ==== src.f ====
rtl/bridge_cfg_pkg.sv
rtl/host_bus_pkg.sv
rtl/fwft_fifo.sv
rtl/host_cmd_decoder.sv
rtl/host_return_arbiter.sv
rtl/pcie_fifo_bridge.sv
tests/pcie_fifo_bridge_sva.sv
tests/pcie_fifo_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: pcie_fifo_bridge

sources:
  # Design sources in compile order
  - files:
      - rtl/bridge_cfg_pkg.sv
      - rtl/host_bus_pkg.sv
      - rtl/fwft_fifo.sv
      - rtl/host_cmd_decoder.sv
      - rtl/host_return_arbiter.sv
      - rtl/pcie_fifo_bridge.sv

  # Bound assertions and testbench, top module pcie_fifo_bridge_tb
  - target: test
    files:
      - tests/pcie_fifo_bridge_sva.sv
      - tests/pcie_fifo_bridge_tb.sv
